/* sgdma_consts.svh */
// sgdma register map, ccr bit positions and descriptor layout
`ifndef SGDMA_CONSTS_SVH
`define SGDMA_CONSTS_SVH

// slave word offsets, taken from adr[4:2]
`define SGDMA_REG_CCR       3'd0
`define SGDMA_REG_STATUS    3'd1
`define SGDMA_REG_DAR       3'd2
`define SGDMA_REG_NDAR      3'd3
`define SGDMA_REG_STATE     3'd4
`define SGDMA_REG_BYTES     3'd5
`define SGDMA_REG_DESCS     3'd6

`define SGDMA_ADR_VALID_BIT 5    // must be zero for a legal access

`define SGDMA_CCR_APPEND    0
`define SGDMA_CCR_ENABLE    1
`define SGDMA_CCR_INT_CLEAR 2
`define SGDMA_CCR_SYS_RST   31

`define SGDMA_DESC_LAST_BIT 0    // in word 0, next pointer sits in 31:3
`define SGDMA_DESC_LEN_OFS  3'd4 // byte offset of word 1

`endif

/* sgdma_pkg.sv */
// sgdma shared types
// wishbone request and response, engine control and status
`default_nettype none

package sgdma_pkg;

   // wishbone classic request, master to slave
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_m2s_t;

   // wishbone classic response, slave to master
   typedef struct packed {
      logic [31:0] dat;
      logic        ack;
      logic        err;
   } wb_s2m_t;

   typedef enum logic [2:0] {
      IDLE,
      FETCH_NEXT,
      FETCH_LEN,
      RECHECK,
      DONE
   } engine_state_e;

   typedef struct packed {
      logic        enable;
      logic        append;
      logic        int_clear;  // one cycle
      logic [31:3] ndar;
      logic        ndar_dirty;
   } dma_ctl_t;

   typedef struct packed {
      logic ndar_dirty_clear;
      logic append_clear;
   } dma_ack_t;

   typedef struct packed {
      logic          busy;
      logic          irq;
      logic          err;
      engine_state_e state;
      logic [31:3]   dar;
      logic [31:0]   byte_count;
      logic [15:0]   desc_count;
   } dma_status_t;

endpackage

`default_nettype wire

/* sgdma_regs.sv */
// sgdma register block
// wishbone classic slave with ccr and ndar, reads back engine status
`default_nettype none
`timescale 1ns/1ps
`include "sgdma_consts.svh"

module sgdma_regs (
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   input  sgdma_pkg::wb_m2s_t     wbs_i,
   output sgdma_pkg::wb_s2m_t     wbs_o,
   output sgdma_pkg::dma_ctl_t    ctl_o,
   input  sgdma_pkg::dma_ack_t    ack_i,
   input  sgdma_pkg::dma_status_t status_i,
   output logic                   sys_rst_o
);

   logic        ack_q;
   logic        err_q;
   logic        req;           // new access seen this cycle
   logic        bad_adr;
   logic [2:0]  ofs;
   logic        wr;
   logic        ccr_we;
   logic        ndar_we;
   logic        enable_q;
   logic        append_q;
   logic        int_clear_q;
   logic        sys_rst_q;
   logic [31:3] ndar_q;
   logic        ndar_dirty_q;
   logic [31:0] ccr_rd;
   logic [31:0] rd_data;

   assign ofs     = wbs_i.adr[4:2];
   assign bad_adr = wbs_i.adr[`SGDMA_ADR_VALID_BIT];

   // blocked while answering, so a held stb gets a one-cycle gap
   assign req     = wbs_i.cyc & wbs_i.stb & ~ack_q & ~err_q;
   assign wr      = req & wbs_i.we & ~bad_adr;
   assign ccr_we  = wr & (ofs == `SGDMA_REG_CCR);
   assign ndar_we = wr & (ofs == `SGDMA_REG_NDAR) & ~enable_q;  // locked while running

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end
      else
      begin
         ack_q <= req & ~bad_adr;
         err_q <= req & bad_adr;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         enable_q  <= 1'b0;
         sys_rst_q <= 1'b0;
      end
      else if (ccr_we)
      begin
         enable_q  <= wbs_i.dat[`SGDMA_CCR_ENABLE];
         sys_rst_q <= wbs_i.dat[`SGDMA_CCR_SYS_RST];
      end
   end

   // int clear only lives for the cycle after the write
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         int_clear_q <= 1'b0;
      else
         int_clear_q <= ccr_we & wbs_i.dat[`SGDMA_CCR_INT_CLEAR];
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         append_q <= 1'b0;
      else if (ccr_we)
         append_q <= wbs_i.dat[`SGDMA_CCR_APPEND];
      else if (ack_i.append_clear)
         append_q <= 1'b0;   // engine used it up
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         ndar_dirty_q <= 1'b0;
      else if (ndar_we)
         ndar_dirty_q <= 1'b1;
      else if (ack_i.ndar_dirty_clear)
         ndar_dirty_q <= 1'b0;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (ndar_we)
         ndar_q <= wbs_i.dat[31:3];
   end

   always_comb
   begin
      ccr_rd                     = '0;
      ccr_rd[`SGDMA_CCR_APPEND]  = append_q;
      ccr_rd[`SGDMA_CCR_ENABLE]  = enable_q;
      ccr_rd[`SGDMA_CCR_SYS_RST] = sys_rst_q;
   end

   always_comb
   begin
      rd_data = '0;
      case (ofs)
         `SGDMA_REG_CCR:    rd_data = ccr_rd;
         `SGDMA_REG_STATUS: rd_data = {29'd0, status_i.err, status_i.busy, status_i.irq};
         `SGDMA_REG_DAR:    rd_data = {status_i.dar, 3'b000};
         `SGDMA_REG_NDAR:   rd_data = {ndar_q, 3'b000};
         `SGDMA_REG_STATE:  rd_data = {29'd0, status_i.state};
         `SGDMA_REG_BYTES:  rd_data = status_i.byte_count;
         `SGDMA_REG_DESCS:  rd_data = {16'd0, status_i.desc_count};
         default:           rd_data = '0;
      endcase
   end

   always_comb
   begin
      wbs_o.dat = rd_data;   // address is still held in the ack cycle
      wbs_o.ack = ack_q;
      wbs_o.err = err_q;
   end

   always_comb
   begin
      ctl_o.enable     = enable_q;
      ctl_o.append     = append_q;
      ctl_o.int_clear  = int_clear_q;
      ctl_o.ndar       = ndar_q;
      ctl_o.ndar_dirty = ndar_dirty_q;
   end

   assign sys_rst_o = wb_rst_i | sys_rst_q;

endmodule

`default_nettype wire

/* sgdma_engine.sv */
// sgdma descriptor engine
// wishbone classic master walking a descriptor chain, sums byte counts
`default_nettype none
`timescale 1ns/1ps
`include "sgdma_consts.svh"

module sgdma_engine (
   input  logic                   wb_clk_i,
   input  logic                   sys_rst_i,
   input  sgdma_pkg::dma_ctl_t    ctl_i,
   output sgdma_pkg::dma_ack_t    ack_o,
   output sgdma_pkg::dma_status_t status_o,
   output sgdma_pkg::wb_m2s_t     wbm_o,
   input  sgdma_pkg::wb_s2m_t     wbm_i,
   output logic                   irq_o
);

   sgdma_pkg::engine_state_e state_q;
   sgdma_pkg::engine_state_e state_d;
   logic [31:3] dar_q;         // current descriptor
   logic [31:3] next_q;        // pointer from word 0
   logic        last_q;
   logic [31:3] follow_adr;
   logic [31:0] byte_count_q;
   logic [15:0] desc_count_q;
   logic        err_q;
   logic        irq_q;
   logic        bus_active;
   logic        bus_ack;
   logic        bus_done;      // ack or err closes the cycle
   logic        start;

   assign bus_active = (state_q == sgdma_pkg::FETCH_NEXT) ||
                       (state_q == sgdma_pkg::FETCH_LEN)  ||
                       (state_q == sgdma_pkg::RECHECK);
   assign bus_ack    = bus_active & wbm_i.ack;
   assign bus_done   = bus_active & (wbm_i.ack | wbm_i.err);
   assign start      = (state_q == sgdma_pkg::IDLE) & ctl_i.enable & ctl_i.ndar_dirty;

   // a recheck that found an extension jumps straight from the read data
   assign follow_adr = (state_q == sgdma_pkg::RECHECK) ? wbm_i.dat[31:3] : next_q;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         sgdma_pkg::IDLE:
         begin
            if (start)
               state_d = sgdma_pkg::FETCH_NEXT;
         end
         sgdma_pkg::FETCH_NEXT:
         begin
            if (wbm_i.ack)
               state_d = sgdma_pkg::FETCH_LEN;
         end
         sgdma_pkg::FETCH_LEN:
         begin
            if (wbm_i.ack)
            begin
               if (!last_q)
                  state_d = sgdma_pkg::FETCH_NEXT;
               else if (ctl_i.append)
                  state_d = sgdma_pkg::RECHECK;   // software may have linked more
               else
                  state_d = sgdma_pkg::DONE;
            end
         end
         sgdma_pkg::RECHECK:
         begin
            if (wbm_i.ack)
            begin
               if (wbm_i.dat[`SGDMA_DESC_LAST_BIT])
                  state_d = sgdma_pkg::DONE;
               else
                  state_d = sgdma_pkg::FETCH_NEXT;
            end
         end
         sgdma_pkg::DONE:
         begin
            if (!ctl_i.enable)
               state_d = sgdma_pkg::IDLE;
         end
         default:
            state_d = sgdma_pkg::IDLE;
      endcase

      // bus error ends the run, disable drops back once the cycle closes
      if (bus_done && wbm_i.err)
         state_d = sgdma_pkg::DONE;
      else if (bus_done && !ctl_i.enable)
         state_d = sgdma_pkg::IDLE;
   end

   always_ff @(posedge wb_clk_i or posedge sys_rst_i)
   begin
      if (sys_rst_i)
      begin
         state_q      <= sgdma_pkg::IDLE;
         dar_q        <= '0;
         byte_count_q <= '0;
         desc_count_q <= '0;
         err_q        <= 1'b0;
         irq_q        <= 1'b0;
      end
      else
      begin
         state_q <= state_d;

         if (start)
         begin
            dar_q        <= ctl_i.ndar;
            byte_count_q <= '0;
            desc_count_q <= '0;
            err_q        <= 1'b0;
         end
         else if (bus_done && state_d == sgdma_pkg::FETCH_NEXT)
            dar_q <= follow_adr;

         if (bus_ack && state_q == sgdma_pkg::FETCH_LEN)
         begin
            byte_count_q <= byte_count_q + wbm_i.dat;
            desc_count_q <= desc_count_q + 16'd1;
         end

         if (bus_done && wbm_i.err)
            err_q <= 1'b1;

         // set wins over a clear in the same cycle
         if (bus_done && state_d == sgdma_pkg::DONE)
            irq_q <= 1'b1;
         else if (ctl_i.int_clear)
            irq_q <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (bus_ack && state_q == sgdma_pkg::FETCH_NEXT)
      begin
         next_q <= wbm_i.dat[31:3];
         last_q <= wbm_i.dat[`SGDMA_DESC_LAST_BIT];
      end
   end

   always_comb
   begin
      wbm_o.cyc = bus_active;
      wbm_o.stb = bus_active;
      wbm_o.we  = 1'b0;        // descriptors are only read
      wbm_o.adr = {dar_q, (state_q == sgdma_pkg::FETCH_LEN) ? `SGDMA_DESC_LEN_OFS : 3'd0};
      wbm_o.dat = '0;
      wbm_o.sel = 4'hf;
   end

   always_comb
   begin
      ack_o.ndar_dirty_clear = start;
      ack_o.append_clear     = bus_done & (state_q == sgdma_pkg::FETCH_LEN) &
                               (state_d == sgdma_pkg::RECHECK);
   end

   always_comb
   begin
      status_o.busy       = bus_active;   // falls with the irq edge at chain end
      status_o.irq        = irq_q;
      status_o.err        = err_q;
      status_o.state      = state_q;
      status_o.dar        = dar_q;
      status_o.byte_count = byte_count_q;
      status_o.desc_count = desc_count_q;
   end

   assign irq_o = irq_q;

endmodule

`default_nettype wire

/* sgdma_top.sv */
// sgdma top level
// register block on the slave port, descriptor engine on the master port
`default_nettype none
`timescale 1ns/1ps

module sgdma_top (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  sgdma_pkg::wb_m2s_t wbs_i,
   output sgdma_pkg::wb_s2m_t wbs_o,
   output sgdma_pkg::wb_m2s_t wbm_o,
   input  sgdma_pkg::wb_s2m_t wbm_i,
   output logic               irq_o,
   output logic               sys_rst_o
);

   sgdma_pkg::dma_ctl_t    dma_ctl;
   sgdma_pkg::dma_ack_t    dma_ack;
   sgdma_pkg::dma_status_t dma_status;

   sgdma_regs u_regs (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .wbs_i     (wbs_i),
      .wbs_o     (wbs_o),
      .ctl_o     (dma_ctl),
      .ack_i     (dma_ack),
      .status_i  (dma_status),
      .sys_rst_o (sys_rst_o)
   );

   // engine runs off the combined hard and soft reset
   sgdma_engine u_engine (
      .wb_clk_i  (wb_clk_i),
      .sys_rst_i (sys_rst_o),
      .ctl_i     (dma_ctl),
      .ack_o     (dma_ack),
      .status_o  (dma_status),
      .wbm_o     (wbm_o),
      .wbm_i     (wbm_i),
      .irq_o     (irq_o)
   );

endmodule

`default_nettype wire

/* sgdma_props.sv */
// sgdma bus and interrupt properties
// bound into the top level, checks both wishbone ports and irq
`default_nettype none
`timescale 1ns/1ps

module sgdma_props (
   input logic                wb_clk_i,
   input logic                wb_rst_i,
   input sgdma_pkg::wb_s2m_t  wbs_o,
   input sgdma_pkg::wb_m2s_t  wbm_o,
   input sgdma_pkg::wb_s2m_t  wbm_i,
   input sgdma_pkg::dma_ctl_t ctl_i,
   input logic                irq_o,
   input logic                sys_rst_o
);

   int excl_fails = 0;
   int pulse_fails = 0;
   int hold_fails = 0;
   int irq_fails = 0;
   int fail_count;

   assign fail_count = excl_fails + pulse_fails + hold_fails + irq_fails;

   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wbs_o.ack && wbs_o.err) && !(wbm_i.ack && wbm_i.err))
   else
   begin
      $error("ack and err high together");
      excl_fails++;
   end

   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) wbs_o.ack |=> !wbs_o.ack)
   else
   begin
      $error("slave ack longer than one cycle");
      pulse_fails++;
   end

   // request stays put until the memory answers
   assert property (@(posedge wb_clk_i) disable iff (sys_rst_o)
      wbm_o.cyc && wbm_o.stb && !wbm_i.ack && !wbm_i.err
      |=> wbm_o.cyc && wbm_o.stb && $stable(wbm_o.adr))
   else
   begin
      $error("master dropped or changed a request before ack or err");
      hold_fails++;
   end

   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $fell(irq_o) |-> $past(ctl_i.int_clear) || sys_rst_o)
   else
   begin
      $error("irq fell without int clear or reset");
      irq_fails++;
   end

endmodule

bind sgdma_top sgdma_props u_props (
   .wb_clk_i  (wb_clk_i),
   .wb_rst_i  (wb_rst_i),
   .wbs_o     (wbs_o),
   .wbm_o     (wbm_o),
   .wbm_i     (wbm_i),
   .ctl_i     (dma_ctl),
   .irq_o     (irq_o),
   .sys_rst_o (sys_rst_o)
);

`default_nettype wire

/* tb_sgdma.sv */
// sgdma testbench
// drives the register port, models descriptor memory with random wait states
`default_nettype none
`timescale 1ns/1ps
`include "sgdma_consts.svh"

module tb_sgdma;

   localparam int          TIMEOUT      = 200;   // cycles per wait
   localparam logic [31:0] CCR_APPEND   = 32'd1 << `SGDMA_CCR_APPEND;
   localparam logic [31:0] CCR_ENABLE   = 32'd1 << `SGDMA_CCR_ENABLE;
   localparam logic [31:0] CCR_INT_CLR  = 32'd1 << `SGDMA_CCR_INT_CLEAR;
   localparam logic [31:0] CCR_SYS_RST  = 32'd1 << `SGDMA_CCR_SYS_RST;
   // three descriptor chain
   localparam logic [31:0] D0 = 32'h20;
   localparam logic [31:0] D1 = 32'h48;
   localparam logic [31:0] D2 = 32'h70;
   localparam logic [31:0] LEN0 = 32'h40;
   localparam logic [31:0] LEN1 = 32'h123;
   localparam logic [31:0] LEN2 = 32'h1000;
   // two descriptor chain for append, one for the bus error
   localparam logic [31:0] A0 = 32'h80;
   localparam logic [31:0] A1 = 32'h90;
   localparam logic [31:0] LEN_A0 = 32'h10;
   localparam logic [31:0] LEN_A1 = 32'h2c;
   localparam int          APPEND_DESCS = 2;
   localparam logic [31:0] E0 = 32'hc0;
   localparam logic [31:0] LEN_E = 32'h77;

   logic               wb_clk = 1'b0;
   logic               wb_rst;
   sgdma_pkg::wb_m2s_t wbs_req;
   sgdma_pkg::wb_s2m_t wbs_rsp;
   sgdma_pkg::wb_m2s_t wbm_req;
   sgdma_pkg::wb_s2m_t wbm_rsp;
   logic               irq;
   logic               sys_rst;

   logic [31:0] mem [0:63];
   int          mem_reads;
   int          wait_left;    // -1 when no request is pending
   logic [15:0] lfsr_q;
   int          errors;
   int          checks;
   int          tests_done;
   bit          timed_out;

   sgdma_top dut (
      .wb_clk_i  (wb_clk),
      .wb_rst_i  (wb_rst),
      .wbs_i     (wbs_req),
      .wbs_o     (wbs_rsp),
      .wbm_o     (wbm_req),
      .wbm_i     (wbm_rsp),
      .irq_o     (irq),
      .sys_rst_o (sys_rst)
   );

   always #5 wb_clk = ~wb_clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16 14 13 11
   endfunction

   function automatic int take_bits(input int n);
      int v;
      int i;
      v = 0;
      for (i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v = (v << 1) | int'(lfsr_q[0]);
      end
      return v;
   endfunction

   function automatic logic [31:0] reg_adr(input logic [2:0] ofs);
      return {27'd0, ofs, 2'b00};
   endfunction

   // descriptor memory, 0 to 3 wait states, err above the 64 words
   initial
   begin
      wbm_rsp   = '0;
      mem_reads = 0;
      wait_left = -1;
      lfsr_q    = 16'd97;
      forever
      begin
         @(posedge wb_clk);
         #1;
         if (wbm_rsp.ack || wbm_rsp.err)
         begin
            wbm_rsp.ack = 1'b0;
            wbm_rsp.err = 1'b0;
         end
         else if (!(wbm_req.cyc && wbm_req.stb))
            wait_left = -1;
         else
         begin
            if (wait_left < 0)
               wait_left = take_bits(2);
            if (wait_left > 0)
               wait_left = wait_left - 1;
            else
            begin
               wait_left = -1;
               if (wbm_req.adr >= 32'h100)
                  wbm_rsp.err = 1'b1;
               else
               begin
                  wbm_rsp.dat = mem[wbm_req.adr[7:2]];
                  wbm_rsp.ack = 1'b1;
                  mem_reads   = mem_reads + 1;
               end
            end
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s", what);
      timed_out = 1'b1;
   endtask

   task automatic finish_test(input string name);
      tests_done++;
      $display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
   endtask

   task automatic put_desc(input logic [31:0] adr, input logic [31:0] next,
                           input logic last, input logic [31:0] len);
      mem[adr[7:2]]        = next | {31'd0, last};
      mem[adr[7:2] + 6'd1] = len;
   endtask

   // one slave access, request held until ack or err
   task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
      int n;
      n = 0;
      @(posedge wb_clk);
      #1;
      wbs_req.cyc = 1'b1;
      wbs_req.stb = 1'b1;
      wbs_req.we  = we;
      wbs_req.adr = adr;
      wbs_req.dat = wdata;
      wbs_req.sel = 4'hf;
      do
      begin
         @(posedge wb_clk);
         #1;
         n++;
      end
      while (!wbs_rsp.ack && !wbs_rsp.err && n < TIMEOUT);
      if (!wbs_rsp.ack && !wbs_rsp.err)
         report_timeout("register block gave neither ack nor err");
      rdata = wbs_rsp.dat;   // still valid while adr is held
      err   = wbs_rsp.err;
      wbs_req.cyc = 1'b0;
      wbs_req.stb = 1'b0;
      wbs_req.we  = 1'b0;
   endtask

   // cycles until the slave answers
   task automatic wait_slave_answer(output int cycles);
      int n;
      n = 0;
      do
      begin
         @(posedge wb_clk);
         #1;
         n++;
      end
      while (!wbs_rsp.ack && !wbs_rsp.err && n < TIMEOUT);
      if (!wbs_rsp.ack && !wbs_rsp.err)
         report_timeout("register block gave neither ack nor err");
      cycles = n;
   endtask

   // two reads with stb kept high across the first ack
   task automatic read_held_pair(input logic [2:0] ofs_a, input logic [2:0] ofs_b,
                                 output logic [31:0] rd_a, output logic [31:0] rd_b,
                                 output int gap);
      int n;
      @(posedge wb_clk);
      #1;
      wbs_req.cyc = 1'b1;
      wbs_req.stb = 1'b1;
      wbs_req.we  = 1'b0;
      wbs_req.adr = reg_adr(ofs_a);
      wbs_req.dat = 32'd0;
      wbs_req.sel = 4'hf;
      wait_slave_answer(n);
      rd_a = wbs_rsp.dat;
      wbs_req.adr = reg_adr(ofs_b);
      wait_slave_answer(gap);
      rd_b = wbs_rsp.dat;
      wbs_req.cyc = 1'b0;
      wbs_req.stb = 1'b0;
   endtask

   task automatic reg_write(input logic [2:0] ofs, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      bus_cycle(1'b1, reg_adr(ofs), data, rd, err);
      check_value("wbs_o.err", 32'(err), 32'd0);
   endtask

   task automatic reg_read(input logic [2:0] ofs, output logic [31:0] data);
      logic err;
      bus_cycle(1'b0, reg_adr(ofs), 32'd0, data, err);
      check_value("wbs_o.err", 32'(err), 32'd0);
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while (irq !== level && n < TIMEOUT)
      begin
         @(posedge wb_clk);
         #1;
         n++;
      end
      if (irq !== level)
         report_timeout($sformatf("irq_o did not go to %0d", level));
   endtask

   task automatic clear_run();
      reg_write(`SGDMA_REG_CCR, 32'd0);   // disable alone keeps irq
      check_value("irq_o", 32'(irq), 32'd1);
      reg_write(`SGDMA_REG_CCR, CCR_INT_CLR);
      wait_irq(1'b0);
   endtask

   task automatic probe_reset_state();
      logic [31:0] rd;
      logic        err;
      logic [31:0] bad;
      bad = 32'd1 << `SGDMA_ADR_VALID_BIT;
      reg_read(`SGDMA_REG_CCR, rd);
      check_value("ccr", rd, 32'd0);
      reg_read(`SGDMA_REG_STATUS, rd);
      check_value("status", rd, 32'd0);
      check_value("irq_o", 32'(irq), 32'd0);
      bus_cycle(1'b1, bad | reg_adr(`SGDMA_REG_CCR), 32'hffff_ffff, rd, err);
      check_value("wbs_o.err", 32'(err), 32'd1);
      bus_cycle(1'b0, bad | reg_adr(`SGDMA_REG_STATUS), 32'd0, rd, err);
      check_value("wbs_o.err", 32'(err), 32'd1);
      reg_read(`SGDMA_REG_CCR, rd);
      check_value("ccr", rd, 32'd0);   // rejected write left it alone
      finish_test("reset values and address error");
   endtask

   task automatic exercise_ndar_lock();
      logic [31:0] rd;
      logic [31:0] rd_b;
      int          gap;
      reg_write(`SGDMA_REG_NDAR, D0 | 32'h7);
      reg_read(`SGDMA_REG_NDAR, rd);
      check_value("ndar", rd, D0);
      read_held_pair(`SGDMA_REG_NDAR, `SGDMA_REG_CCR, rd, rd_b, gap);
      check_value("ndar", rd, D0);
      check_value("ccr", rd_b, 32'd0);
      check_value("wbs_o.ack cycles", 32'(gap), 32'd2);   // one idle cycle between acks
      reg_write(`SGDMA_REG_CCR, CCR_ENABLE);   // starts the three descriptor chain
      reg_write(`SGDMA_REG_NDAR, 32'hf8);
      reg_read(`SGDMA_REG_NDAR, rd);
      check_value("ndar", rd, D0);
      finish_test("ndar write and lock");
   endtask

   task automatic walk_three_descriptors();
      logic [31:0] rd;
      wait_irq(1'b1);
      reg_read(`SGDMA_REG_STATUS, rd);
      check_value("status", rd, 32'h1);   // irq only, busy low
      reg_read(`SGDMA_REG_BYTES, rd);
      check_value("byte_count", rd, LEN0 + LEN1 + LEN2);
      reg_read(`SGDMA_REG_DESCS, rd);
      check_value("desc_count", rd, 32'd3);
      reg_read(`SGDMA_REG_DAR, rd);
      check_value("dar", rd, D2);
      clear_run();
      finish_test("three descriptor chain");
   endtask

   task automatic recheck_after_append();
      logic [31:0] rd;
      int          reads_start;
      reg_write(`SGDMA_REG_NDAR, A0);
      reads_start = mem_reads;
      reg_write(`SGDMA_REG_CCR, CCR_ENABLE | CCR_APPEND);
      wait_irq(1'b1);
      reg_read(`SGDMA_REG_CCR, rd);
      check_value("ccr.append", 32'(rd[`SGDMA_CCR_APPEND]), 32'd0);
      check_value("memory reads", 32'(mem_reads - reads_start), 32'(2 * APPEND_DESCS + 1));
      reg_read(`SGDMA_REG_BYTES, rd);
      check_value("byte_count", rd, LEN_A0 + LEN_A1);
      clear_run();
      finish_test("append recheck");
   endtask

   task automatic force_bus_error();
      logic [31:0] rd;
      reg_write(`SGDMA_REG_NDAR, E0);
      reg_write(`SGDMA_REG_CCR, CCR_ENABLE);
      wait_irq(1'b1);
      reg_read(`SGDMA_REG_STATUS, rd);
      check_value("status", rd, 32'h5);   // err and irq
      reg_read(`SGDMA_REG_BYTES, rd);
      check_value("byte_count", rd, LEN_E);
      clear_run();
      reg_write(`SGDMA_REG_CCR, CCR_SYS_RST);
      check_value("sys_rst_o", 32'(sys_rst), 32'd1);
      reg_read(`SGDMA_REG_BYTES, rd);
      check_value("byte_count", rd, 32'd0);
      reg_read(`SGDMA_REG_DESCS, rd);
      check_value("desc_count", rd, 32'd0);
      reg_write(`SGDMA_REG_CCR, 32'd0);
      check_value("sys_rst_o", 32'(sys_rst), 32'd0);
      finish_test("bus error, int clear and soft reset");
   endtask

   initial
   begin
      int total;
      int i;
      wb_rst     = 1'b1;
      wbs_req    = '0;
      errors     = 0;
      checks     = 0;
      tests_done = 0;
      timed_out  = 1'b0;
      for (i = 0; i < 64; i++)
         mem[i] = 32'hc0de_0000 | (i << 2);
      put_desc(D0, D1, 1'b0, LEN0);
      put_desc(D1, D2, 1'b0, LEN1);
      put_desc(D2, 32'd0, 1'b1, LEN2);
      put_desc(A0, A1, 1'b0, LEN_A0);
      put_desc(A1, 32'd0, 1'b1, LEN_A1);
      put_desc(E0, 32'h100, 1'b0, LEN_E);   // points past the memory
      repeat (2) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      probe_reset_state();
      if (!timed_out)
         exercise_ndar_lock();
      if (!timed_out)
         walk_three_descriptors();
      if (!timed_out)
         recheck_after_append();
      if (!timed_out)
         force_bus_error();

      total = errors + dut.u_props.fail_count;
      $display("%0d tests, %0d checks, %0d errors", tests_done, checks, total);
      if (timed_out || total != 0)
         $display("Testbench failed");
      else
         $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
sgdma_pkg.sv
sgdma_regs.sv
sgdma_engine.sv
sgdma_top.sv
sgdma_props.sv
tb_sgdma.sv

/* run.sh */
#!/bin/sh
# build the sgdma testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_sgdma \
   -f filelist.f -o sim_sgdma &&
./obj_dir/sim_sgdma | tee /dev/stderr | grep -q "^Testbench passed$" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
